// ==== rtl/isaPkg.sv ====
package isaPkg;

    // bit positions of the instruction fields.
    localparam int kindHi     = 31;
    localparam int kindLo     = 30;
    localparam int storingBit = 29;
    localparam int derefBit   = 28;
    localparam int zHi        = 27;
    localparam int zLo        = 24;
    localparam int xHi        = 23;
    localparam int xLo        = 20;
    localparam int yHi        = 19;
    localparam int yLo        = 16;
    localparam int opHi       = 15;
    localparam int opLo       = 12;
    localparam int immHi      = 11; // immediate is signed.
    localparam int immLo      = 0;

    localparam logic [3:0] opOr    = 4'h0;
    localparam logic [3:0] opAnd   = 4'h1;
    localparam logic [3:0] opAdd   = 4'h2;
    localparam logic [3:0] opMul   = 4'h3;
    localparam logic [3:0] opRsvd  = 4'h4; // gives zero.
    localparam logic [3:0] opShl   = 4'h5;
    localparam logic [3:0] opLtNeg = 4'h6; // all ones when true.
    localparam logic [3:0] opEqNeg = 4'h7;
    localparam logic [3:0] opGeNeg = 4'h8;
    localparam logic [3:0] opAndn  = 4'h9;
    localparam logic [3:0] opXor   = 4'ha;
    localparam logic [3:0] opSub   = 4'hb;
    localparam logic [3:0] opXnor  = 4'hc;
    localparam logic [3:0] opShr   = 4'hd;
    localparam logic [3:0] opNeq   = 4'he;
    localparam logic [3:0] opSra   = 4'hf;

    // order of (A, B, C) taken from X, Y and the immediate.
    localparam logic [1:0] kindXYI  = 2'd0;
    localparam logic [1:0] kindXIY  = 2'd1;
    localparam logic [1:0] kindIXY  = 2'd2;
    localparam logic [1:0] kindRsvd = 2'd3;

    localparam logic [3:0] regZero = 4'd0;
    localparam logic [3:0] regPc   = 4'd15;

endpackage

// ==== rtl/corePkg.sv ====
package corePkg;

    localparam int dataWidth = 32;

    // steps of one instruction.
    typedef enum logic [2:0] {
        stFetch = 3'd0, // instruction memory wait, halt is checked here.
        stIssue = 3'd1,
        stExec  = 3'd2,
        stMem   = 3'd3, // loads and stores only.
        stWrite = 3'd4,
        stNext  = 3'd5
    } ctrlState;

endpackage

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          regWrite,
    input  logic [3:0]                    writeIdx,
    input  logic [corePkg::dataWidth-1:0] writeData,
    input  logic [corePkg::dataWidth-1:0] nextPc,
    input  logic [3:0]                    idxX,
    input  logic [3:0]                    idxY,
    input  logic [3:0]                    idxZ,
    output logic [corePkg::dataWidth-1:0] valX,
    output logic [corePkg::dataWidth-1:0] valY,
    output logic [corePkg::dataWidth-1:0] valZ
);

    logic [corePkg::dataWidth-1:0] regs [1:14]; // 0 and 15 have no storage.

    assign valX = (idxX == isaPkg::regZero) ? '0 :
                  (idxX == isaPkg::regPc)   ? nextPc : regs[idxX];
    assign valY = (idxY == isaPkg::regZero) ? '0 :
                  (idxY == isaPkg::regPc)   ? nextPc : regs[idxY];
    assign valZ = (idxZ == isaPkg::regZero) ? '0 :
                  (idxZ == isaPkg::regPc)   ? nextPc : regs[idxZ];

    always_ff @(posedge clk) begin
        if (regWrite && writeIdx != isaPkg::regZero && writeIdx != isaPkg::regPc) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

// ==== rtl/insnDecode.sv ====
`timescale 1ns/1ps

module insnDecode (
    input  logic [corePkg::dataWidth-1:0] insn,
    input  logic [corePkg::dataWidth-1:0] valX,
    input  logic [corePkg::dataWidth-1:0] valY,
    output logic [3:0]                    idxX,
    output logic [3:0]                    idxY,
    output logic [3:0]                    idxZ,
    output logic [3:0]                    op,
    output logic                          storing,
    output logic                          loading,
    output logic                          derefRhs,
    output logic                          branching,
    output logic [corePkg::dataWidth-1:0] valA,
    output logic [corePkg::dataWidth-1:0] valB,
    output logic [corePkg::dataWidth-1:0] valC
);

    localparam int ImmWidth = isaPkg::immHi - isaPkg::immLo + 1;

    logic [1:0]                    kind;
    logic [corePkg::dataWidth-1:0] valI;

    assign kind     = insn[isaPkg::kindHi:isaPkg::kindLo];
    assign storing  = insn[isaPkg::storingBit];
    assign derefRhs = insn[isaPkg::derefBit];
    assign idxZ     = insn[isaPkg::zHi:isaPkg::zLo];
    assign idxX     = insn[isaPkg::xHi:isaPkg::xLo];
    assign idxY     = insn[isaPkg::yHi:isaPkg::yLo];
    assign op       = insn[isaPkg::opHi:isaPkg::opLo];
    assign valI     = {{(corePkg::dataWidth - ImmWidth){insn[isaPkg::immHi]}},
                       insn[isaPkg::immHi:isaPkg::immLo]};

    assign loading   = derefRhs && !storing;
    assign branching = (idxZ == isaPkg::regPc) && !storing; // a write to pc.

    always_comb begin
        case (kind)
            isaPkg::kindXIY: begin
                valA = valX;
                valB = valI;
                valC = valY;
            end
            isaPkg::kindIXY: begin
                valA = valI;
                valB = valX;
                valC = valY;
            end
            default: begin // kindXYI and kindRsvd.
                valA = valX;
                valB = valY;
                valC = valI;
            end
        endcase
    end

endmodule

// ==== rtl/aluExec.sv ====
`timescale 1ns/1ps

module aluExec (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic [3:0]                    op,
    input  logic [corePkg::dataWidth-1:0] valA,
    input  logic [corePkg::dataWidth-1:0] valB,
    input  logic [corePkg::dataWidth-1:0] valC,
    output logic                          done,
    output logic [corePkg::dataWidth-1:0] result
);

    localparam int W = corePkg::dataWidth;

    logic [2:0]   stageValid;
    logic [3:0]   opS1;
    logic [W-1:0] aS1, bS1, cS1;
    logic [W-1:0] opValue;
    logic [W-1:0] yS2, cS2;
    logic [W-1:0] zS3;

    always_comb begin
        case (opS1)
            isaPkg::opOr:    opValue = aS1 | bS1;
            isaPkg::opAnd:   opValue = aS1 & bS1;
            isaPkg::opAdd:   opValue = aS1 + bS1;
            isaPkg::opMul:   opValue = aS1 * bS1;
            isaPkg::opShl:   opValue = aS1 << bS1;
            isaPkg::opLtNeg: opValue = {W{$signed(aS1) < $signed(bS1)}};
            isaPkg::opEqNeg: opValue = {W{aS1 == bS1}};
            isaPkg::opGeNeg: opValue = {W{$signed(aS1) >= $signed(bS1)}};
            isaPkg::opAndn:  opValue = aS1 & ~bS1;
            isaPkg::opXor:   opValue = aS1 ^ bS1;
            isaPkg::opSub:   opValue = aS1 - bS1;
            isaPkg::opXnor:  opValue = aS1 ~^ bS1;
            isaPkg::opShr:   opValue = aS1 >> bS1;
            isaPkg::opNeq:   opValue = {W{aS1 != bS1}};
            isaPkg::opSra:   opValue = $unsigned($signed(aS1) >>> bS1);
            isaPkg::opRsvd:  opValue = '0;
            default:         opValue = '0;
        endcase
    end

    // data stages run freely, C rides along until the add.
    always_ff @(posedge clk) begin
        opS1   <= op;
        aS1    <= valA;
        bS1    <= valB;
        cS1    <= valC;
        yS2    <= opValue;
        cS2    <= cS1;
        zS3    <= yS2 + cS2;
        result <= zS3;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stageValid <= '0;
            done       <= 1'b0;
        end else begin
            stageValid <= {stageValid[1:0], start};
            done       <= stageValid[2];
        end
    end

endmodule

// ==== rtl/memWaitTimer.sv ====
`timescale 1ns/1ps

module memWaitTimer #(
    parameter int MemWaitCycles = 3
) (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    output logic done
);

    localparam int CountWidth = $clog2(MemWaitCycles + 1);

    logic [CountWidth-1:0] count;

    assign done = (count == CountWidth'(1)); // last cycle of the wait.

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= CountWidth'(MemWaitCycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== rtl/coreControl.sv ====
`timescale 1ns/1ps

module coreControl #(
    parameter logic [corePkg::dataWidth-1:0] ResetVector = '0
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          halt,
    output logic                          timerStart,
    input  logic                          timerDone,
    output logic                          execStart,
    input  logic                          execDone,
    input  logic [corePkg::dataWidth-1:0] execResult,
    input  logic                          storing,
    input  logic                          loading,
    input  logic                          derefRhs,
    input  logic                          branching,
    input  logic [corePkg::dataWidth-1:0] valZ,
    output logic [corePkg::dataWidth-1:0] iAddr,
    input  logic [corePkg::dataWidth-1:0] iData,
    output logic [corePkg::dataWidth-1:0] insn,
    output logic [corePkg::dataWidth-1:0] nextPc,
    output logic                          regWrite,
    output logic [corePkg::dataWidth-1:0] writeData,
    output logic                          dStrobe,
    output logic                          dWrite,
    output logic [corePkg::dataWidth-1:0] dAddr,
    output logic [corePkg::dataWidth-1:0] dWdata,
    input  logic [corePkg::dataWidth-1:0] dRdata
);

    corePkg::ctrlState             state;
    logic                          fetchBusy; // fetch wait is running.
    logic [corePkg::dataWidth-1:0] pc;
    logic [corePkg::dataWidth-1:0] rhs;
    logic [corePkg::dataWidth-1:0] loadData;

    assign iAddr     = pc;
    assign writeData = loading ? loadData : rhs;
    assign regWrite  = (state == corePkg::stWrite) && !storing;
    assign dWrite    = dStrobe && storing;
    // deref picks which of rhs and Z is the address.
    assign dAddr     = derefRhs ? rhs : valZ;
    assign dWdata    = derefRhs ? valZ : rhs;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= corePkg::stFetch;
            pc         <= ResetVector;
            nextPc     <= ResetVector + 1'b1;
            fetchBusy  <= 1'b0;
            timerStart <= 1'b0;
            execStart  <= 1'b0;
            dStrobe    <= 1'b0;
        end else begin
            timerStart <= 1'b0;
            execStart  <= 1'b0;
            case (state)
                corePkg::stFetch: begin
                    if (!fetchBusy && !halt) begin
                        timerStart <= 1'b1;
                        fetchBusy  <= 1'b1;
                    end
                    if (timerDone) begin
                        fetchBusy <= 1'b0;
                        state     <= corePkg::stIssue;
                    end
                end
                corePkg::stIssue: begin
                    execStart <= 1'b1;
                    state     <= corePkg::stExec;
                end
                corePkg::stExec: begin
                    if (execDone && (loading || storing)) begin
                        timerStart <= 1'b1; // wait runs alongside stMem.
                        state      <= corePkg::stMem;
                    end else if (execDone) begin
                        state <= corePkg::stWrite;
                    end
                end
                corePkg::stMem: begin
                    if (timerStart) dStrobe <= 1'b1;
                    if (timerDone) begin
                        dStrobe <= 1'b0;
                        state   <= corePkg::stWrite;
                    end
                end
                corePkg::stWrite: begin
                    pc    <= branching ? writeData : nextPc;
                    state <= corePkg::stNext;
                end
                default: begin // stNext.
                    nextPc <= pc + 1'b1;
                    state  <= corePkg::stFetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == corePkg::stFetch && timerDone) insn <= iData;
        if (state == corePkg::stExec && execDone) rhs <= execResult;
        if (state == corePkg::stMem && timerDone) loadData <= dRdata; // last strobe cycle.
    end

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
    parameter logic [corePkg::dataWidth-1:0] ResetVector   = '0,
    parameter int                            MemWaitCycles = 3
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          halt,
    output logic [corePkg::dataWidth-1:0] iAddr,
    input  logic [corePkg::dataWidth-1:0] iData,
    output logic                          dStrobe,
    output logic                          dWrite,
    output logic [corePkg::dataWidth-1:0] dAddr,
    output logic [corePkg::dataWidth-1:0] dWdata,
    input  logic [corePkg::dataWidth-1:0] dRdata
);

    logic                          timerStart, timerDone;
    logic                          execStart, execDone;
    logic [corePkg::dataWidth-1:0] execResult;
    logic                          storing, loading, derefRhs, branching;
    logic [3:0]                    idxX, idxY, idxZ, op;
    logic [corePkg::dataWidth-1:0] valX, valY, valZ;
    logic [corePkg::dataWidth-1:0] valA, valB, valC;
    logic [corePkg::dataWidth-1:0] insn, nextPc, writeData;
    logic                          regWrite;

    regFile regs (
        .clk(clk), .regWrite(regWrite), .writeIdx(idxZ), .writeData(writeData),
        .nextPc(nextPc), .idxX(idxX), .idxY(idxY), .idxZ(idxZ),
        .valX(valX), .valY(valY), .valZ(valZ)
    );

    insnDecode decoder (
        .insn(insn), .valX(valX), .valY(valY),
        .idxX(idxX), .idxY(idxY), .idxZ(idxZ), .op(op),
        .storing(storing), .loading(loading), .derefRhs(derefRhs), .branching(branching),
        .valA(valA), .valB(valB), .valC(valC)
    );

    aluExec alu (
        .clk(clk), .reset_n(reset_n), .start(execStart), .op(op),
        .valA(valA), .valB(valB), .valC(valC),
        .done(execDone), .result(execResult)
    );

    // one timer serves both the fetch and the data access.
    memWaitTimer #(.MemWaitCycles(MemWaitCycles)) waitTimer (
        .clk(clk), .reset_n(reset_n), .start(timerStart), .done(timerDone)
    );

    coreControl #(.ResetVector(ResetVector)) control (
        .clk(clk), .reset_n(reset_n), .halt(halt),
        .timerStart(timerStart), .timerDone(timerDone),
        .execStart(execStart), .execDone(execDone), .execResult(execResult),
        .storing(storing), .loading(loading), .derefRhs(derefRhs), .branching(branching),
        .valZ(valZ), .iAddr(iAddr), .iData(iData), .insn(insn), .nextPc(nextPc),
        .regWrite(regWrite), .writeData(writeData),
        .dStrobe(dStrobe), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
        .dRdata(dRdata)
    );

endmodule

// ==== verif/cpuCore_assertions.sv ====
`timescale 1ns/1ps

module cpuCoreAssertions #(
    parameter int MemWaitCycles = 3
) (
    input logic        clk,
    input logic        reset_n,
    input logic        dStrobe,
    input logic        dWrite,
    input logic [31:0] dAddr,
    input logic [31:0] dWdata
);

    int strobeLen;

    always_ff @(posedge clk) begin
        strobeLen <= dStrobe ? strobeLen + 1 : 0;
    end

    writeNeedsStrobe: assert property (@(posedge clk) disable iff (!reset_n)
        dWrite |-> dStrobe) else $error("dWrite high without dStrobe");

    noStrobeInReset: assert property (@(posedge clk)
        !reset_n |=> !dStrobe) else $error("dStrobe high after a reset cycle");

    stableDuringAccess: assert property (@(posedge clk) disable iff (!reset_n)
        dStrobe && $past(dStrobe) |-> $stable(dAddr) && $stable(dWdata) && $stable(dWrite))
        else $error("data port changed during an access");

    strobeLength: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(dStrobe) |-> strobeLen == MemWaitCycles)
        else $error("dStrobe length differs from the wait count");

endmodule

bind cpuCore cpuCoreAssertions #(.MemWaitCycles(MemWaitCycles)) memChecks (
    .clk(clk), .reset_n(reset_n), .dStrobe(dStrobe), .dWrite(dWrite),
    .dAddr(dAddr), .dWdata(dWdata)
);

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

    localparam logic [31:0] ResetVector   = 32'd0;
    localparam int          MemWaitCycles = 3;
    localparam int          ProgLen       = 60; // last word is the self-loop.
    localparam int          W             = corePkg::dataWidth;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         halt;
    logic [W-1:0] iAddr, iData, dAddr, dWdata, dRdata;
    logic         dStrobe, dWrite;

    logic [W-1:0] imem [0:63];
    logic [W-1:0] dMem [0:15];
    logic [W-1:0] refMem [0:15];
    logic [W-1:0] refRegs [0:15];
    logic [31:0]  lfsrState = 32'h57693fe6;
    logic [W-1:0] expAddr [$];
    logic [W-1:0] expData [$];
    logic         expWrite [$];
    logic [W-1:0] expNextPc, prevAddr;
    logic         started;
    int           strobeLen, valueErrors, otherErrors;

    cpuCore #(.ResetVector(ResetVector), .MemWaitCycles(MemWaitCycles)) dut (
        .clk(clk), .reset_n(reset_n), .halt(halt), .iAddr(iAddr), .iData(iData),
        .dStrobe(dStrobe), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
        .dRdata(dRdata)
    );

    always #10 clk = ~clk;

    // both memories answer combinationally, data wraps into 16 words.
    assign iData  = (iAddr < 32'd64) ? imem[iAddr[5:0]] : '0;
    assign dRdata = dMem[dAddr[3:0]];

    always @(posedge clk) begin
        if (dStrobe && dWrite) dMem[dAddr[3:0]] <= dWdata;
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input logic [1:0] kind, input logic st,
            input logic deref, input logic [3:0] z, x, y, op, input logic [11:0] imm);
        logic [31:0] w;
        w = '0;
        w[isaPkg::kindHi:isaPkg::kindLo] = kind;
        w[isaPkg::storingBit]            = st;
        w[isaPkg::derefBit]              = deref;
        w[isaPkg::zHi:isaPkg::zLo]       = z;
        w[isaPkg::xHi:isaPkg::xLo]       = x;
        w[isaPkg::yHi:isaPkg::yLo]       = y;
        w[isaPkg::opHi:isaPkg::opLo]     = op;
        w[isaPkg::immHi:isaPkg::immLo]   = imm;
        return w;
    endfunction

    // operation table of the ISA.
    function automatic logic [W-1:0] applyOp(input logic [3:0] op, input logic [W-1:0] a, b);
        case (op)
            isaPkg::opOr:    return a | b;
            isaPkg::opAnd:   return a & b;
            isaPkg::opAdd:   return a + b;
            isaPkg::opMul:   return a * b;
            isaPkg::opShl:   return a << b;
            isaPkg::opLtNeg: return ($signed(a) < $signed(b)) ? '1 : '0;
            isaPkg::opEqNeg: return (a == b) ? '1 : '0;
            isaPkg::opGeNeg: return ($signed(a) >= $signed(b)) ? '1 : '0;
            isaPkg::opAndn:  return a & ~b;
            isaPkg::opXor:   return a ^ b;
            isaPkg::opSub:   return a - b;
            isaPkg::opXnor:  return ~(a ^ b);
            isaPkg::opShr:   return a >> b;
            isaPkg::opNeq:   return (a != b) ? '1 : '0;
            isaPkg::opSra:   return $unsigned($signed(a) >>> b);
            default:         return '0;
        endcase
    endfunction

    function automatic logic [W-1:0] readReg(input logic [3:0] idx, input logic [W-1:0] pc);
        if (idx == isaPkg::regZero) return '0;
        if (idx == isaPkg::regPc) return pc + 1;
        return refRegs[idx];
    endfunction

    task automatic checkData(input string name, input logic [W-1:0] exp, act);
        if (act !== exp) begin
            valueErrors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, act);
        if (act !== exp) begin
            valueErrors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ISA reference step for the word at pc, queues the expected access.
    task automatic stepModel(input logic [W-1:0] pc);
        logic [31:0]  ins;
        logic [W-1:0] x, y, z, imm, a, b, c, rhs, addr, data, wval;
        logic [3:0]   zi;
        ins  = imem[pc[5:0]];
        zi   = ins[isaPkg::zHi:isaPkg::zLo];
        x    = readReg(ins[isaPkg::xHi:isaPkg::xLo], pc);
        y    = readReg(ins[isaPkg::yHi:isaPkg::yLo], pc);
        z    = readReg(zi, pc);
        imm  = W'($signed(ins[isaPkg::immHi:isaPkg::immLo]));
        a    = x;
        b    = y;
        c    = imm;
        if (ins[isaPkg::kindHi:isaPkg::kindLo] == isaPkg::kindXIY) begin
            b = imm;
            c = y;
        end else if (ins[isaPkg::kindHi:isaPkg::kindLo] == isaPkg::kindIXY) begin
            a = imm;
            b = x;
            c = y;
        end
        rhs       = applyOp(ins[isaPkg::opHi:isaPkg::opLo], a, b) + c;
        expNextPc = pc + 1;
        if (ins[isaPkg::storingBit]) begin
            addr = ins[isaPkg::derefBit] ? rhs : z;
            data = ins[isaPkg::derefBit] ? z : rhs;
            refMem[addr[3:0]] = data;
            expAddr.push_back(addr);
            expData.push_back(data);
            expWrite.push_back(1'b1);
        end else begin
            wval = rhs;
            if (ins[isaPkg::derefBit]) begin
                wval = refMem[rhs[3:0]];
                expAddr.push_back(rhs);
                expData.push_back(wval);
                expWrite.push_back(1'b0);
            end
            if (zi == isaPkg::regPc) expNextPc = wval; // a branch.
            else if (zi != isaPkg::regZero) refRegs[zi] = wval;
        end
    endtask

    task automatic buildProgram();
        logic [2:0]  sel;
        logic [3:0]  z;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        for (int i = 0; i < 14; i++) begin // give every register a value.
            imem[i] = encode(isaPkg::kindXYI, 1'b0, 1'b0, 4'(i + 1), 4'd0, 4'd0,
                             isaPkg::opOr, 12'(randBits(12)));
        end
        for (int pc = 14; pc < ProgLen - 1; pc++) begin
            sel = 3'(randBits(3));
            z   = 4'(randBits(4));
            if (z == isaPkg::regPc) z = 4'd14;
            if (sel < 3'd2) begin
                imem[pc] = encode(2'(randBits(2)), 1'b1, 1'(randBits(1)), 4'(randBits(4)),
                                  4'(randBits(4)), 4'(randBits(4)), 4'(randBits(4)),
                                  12'(randBits(12)));
            end else if (sel == 3'd2) begin
                imem[pc] = encode(2'(randBits(2)), 1'b0, 1'b1, z, 4'(randBits(4)),
                                  4'(randBits(4)), 4'(randBits(4)), 12'(randBits(12)));
            end else if (sel == 3'd3 && pc + 4 < ProgLen - 1) begin
                imem[pc] = encode(isaPkg::kindXYI, 1'b0, 1'b0, isaPkg::regPc, 4'd0, 4'd0,
                                  isaPkg::opOr, 12'(pc + 1 + int'(randBits(2))));
            end else begin
                imem[pc] = encode(2'(randBits(2)), 1'b0, 1'b0, z, 4'(randBits(4)),
                                  4'(randBits(4)), 4'(randBits(4)), 12'(randBits(12)));
            end
        end
        imem[ProgLen - 1] = encode(isaPkg::kindXYI, 1'b0, 1'b0, isaPkg::regPc, 4'd0, 4'd0,
                                   isaPkg::opOr, 12'(ProgLen - 1));
    endtask

    // fetch and data port monitor, one model step per new fetch address.
    always @(posedge clk) begin
        if (!reset_n) begin
            started = 1'b0;
        end else begin
            if (!started) begin
                checkData("reset vector", ResetVector, iAddr);
                stepModel(iAddr);
                prevAddr = iAddr;
                started  = 1'b1;
            end else if (iAddr != prevAddr) begin
                checkData("next fetch address", expNextPc, iAddr);
                prevAddr = iAddr;
                stepModel(iAddr);
            end
            if (dStrobe && strobeLen == 0) begin
                if (expAddr.size() == 0) begin
                    otherErrors++;
                    $display("data access seen that no instruction asked for");
                end else begin
                    checkData("access address", expAddr[0], dAddr);
                    checkFlag("access dWrite", expWrite[0], dWrite);
                    if (expWrite[0]) checkData("store data", expData[0], dWdata);
                    else checkData("load data", expData[0], dRdata);
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                    void'(expWrite.pop_front());
                end
            end
            if (dStrobe) begin
                strobeLen++;
            end else if (strobeLen != 0) begin
                checkData("strobe length", W'(MemWaitCycles), W'(strobeLen));
                strobeLen = 0;
            end
        end
    end

    initial begin
        int          waited;
        logic [W-1:0] holdAddr;
        reset_n     <= 1'b0;
        halt        <= 1'b0;
        started      = 1'b0;
        strobeLen    = 0;
        valueErrors  = 0;
        otherErrors  = 0;
        for (int i = 0; i < 16; i++) begin
            refMem[i]  = 32'h3c5a_0000 ^ (32'(i) * 32'h0101_1011);
            dMem[i]   <= refMem[i];
            refRegs[i] = '0;
        end
        buildProgram();
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        waited = 0;
        while (iAddr < 32'd20 && waited < 5000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 5000) begin
            otherErrors++;
            $display("timeout before the halt test point was reached");
        end
        halt <= 1'b1;
        repeat (30) @(posedge clk); // lets the instruction in flight retire.
        holdAddr = iAddr;
        repeat (20) begin
            @(posedge clk);
            checkData("halted iAddr", holdAddr, iAddr);
            checkFlag("halted dStrobe", 1'b0, dStrobe);
        end
        halt <= 1'b0;

        waited = 0;
        while (iAddr != 32'(ProgLen - 1) && waited < 30000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 30000) begin
            otherErrors++;
            $display("timeout, the program never reached its final loop");
        end
        repeat (40) @(posedge clk);
        if (expAddr.size() != 0) begin
            otherErrors++;
            $display("%0d expected data accesses never happened", expAddr.size());
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/regFile.sv
rtl/insnDecode.sv
rtl/aluExec.sv
rtl/memWaitTimer.sv
rtl/coreControl.sv
rtl/cpuCore.sv
verif/cpuCore_assertions.sv
verif/cpuCoreTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f tb.f -o simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
